//--- all.f
design/bridge_pkg.sv
design/req_arbiter.sv
design/write_burst.sv
design/read_return.sv
design/axi_bridge_top.sv
dv/axi_mem_model.sv
dv/tb_axi_bridge.sv

//--- Bender.yml
package:
  name: axi_bridge

sources:
  - design/bridge_pkg.sv
  - design/req_arbiter.sv
  - design/write_burst.sv
  - design/read_return.sv
  - design/axi_bridge_top.sv
  - target: simulation
    files:
      - dv/axi_mem_model.sv
      - dv/tb_axi_bridge.sv

//--- dv/tb_axi_bridge.sv
`timescale 1ns/100ps

module tb_axi_bridge import bridge_pkg::*; ();

  localparam int rows  = 10;
  localparam int limit = rows * 64 + 100;

  logic aclk;
  logic rst_n;
  logic inst_rd_req, inst_rd_rdy, inst_ret_valid, inst_ret_last;
  req_type_e inst_rd_type;
  logic [addr_w-1:0] inst_rd_addr;
  logic [word_w-1:0] inst_ret_data;
  logic data_rd_req, data_rd_rdy, data_ret_valid, data_ret_last;
  req_type_e data_rd_type;
  logic [addr_w-1:0] data_rd_addr;
  logic [word_w-1:0] data_ret_data;
  logic data_wr_req, data_wr_rdy;
  req_type_e data_wr_type;
  logic [addr_w-1:0] data_wr_addr;
  logic [3:0] data_wr_wstrb;
  logic [line_w-1:0] data_wr_data;
  logic [3:0] arid, rid, awid, bid, wstrb;
  logic [addr_w-1:0] araddr, awaddr;
  logic [7:0] arlen, awlen;
  logic [2:0] arsize, awsize;
  logic [1:0] arburst, awburst;
  logic arvalid, arready, rlast, rvalid, rready;
  logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
  logic [word_w-1:0] rdata, wdata;

  // row op is 0 inst read, 1 data read, 2 data write or 3 both reads with data at addr + 0x100
  logic [1:0]        op_tab [rows];
  req_type_e         type_tab [rows];
  logic [addr_w-1:0] addr_tab [rows];
  logic [line_w-1:0] data_tab [rows];
  logic [3:0]        strb_tab [rows];
  logic [31:0]       shadow [0:1023];
  int                cycles;

  // expected address channel payload, read side indexed by id
  logic [addr_w-1:0] ar_addr_exp [2];
  logic [7:0]        ar_len_exp;
  logic [2:0]        ar_size_exp;
  logic [addr_w-1:0] aw_addr_exp;
  logic [7:0]        aw_len_exp;
  logic [2:0]        aw_size_exp;

  axi_bridge_top UUT (.*);
  axi_mem_model u_mem (.*);

  always #50 aclk = ~aclk;

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("*** FAILED ***");
      $fatal(1, "timeout: the run went past its cycle limit");
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("ERR %0t: %s got %h expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  // ar and aw payload at each handshake
  always @(posedge aclk) begin
    if (rst_n && arvalid && arready) begin
      check_value(arid[3:1], 0, "arid");
      check_value(araddr, ar_addr_exp[arid[0]], "araddr");
      check_value(arlen, ar_len_exp, "arlen");
      check_value(arsize, ar_size_exp, "arsize");
      check_value(arburst, 2'b01, "arburst");
    end
    if (rst_n && awvalid && awready) begin
      check_value(awid, 4'd1, "awid");
      check_value(awaddr, aw_addr_exp, "awaddr");
      check_value(awlen, aw_len_exp, "awlen");
      check_value(awsize, aw_size_exp, "awsize");
      check_value(awburst, 2'b01, "awburst");
    end
  end

  task automatic set_row(input int i, input logic [1:0] op, input req_type_e t,
                         input logic [31:0] a, input logic [127:0] d, input logic [3:0] s);
    op_tab[i]   = op;
    type_tab[i] = t;
    addr_tab[i] = a;
    data_tab[i] = d;
    strb_tab[i] = s;
  endtask

  function automatic int beat_count(input req_type_e t);
    return (t == req_line) ? line_beats : 1;
  endfunction

  task automatic send_write(input int i);
    logic [9:0] w;
    @(posedge aclk);
    data_wr_req   <= 1'b1;
    data_wr_type  <= type_tab[i];
    data_wr_addr  <= addr_tab[i];
    data_wr_wstrb <= strb_tab[i];
    data_wr_data  <= data_tab[i];
    do @(posedge aclk); while (!(data_wr_req && data_wr_rdy));
    data_wr_req <= 1'b0;
    aw_addr_exp = addr_tab[i];
    aw_len_exp  = 8'(beat_count(type_tab[i]) - 1);
    aw_size_exp = (type_tab[i] == req_line) ? 3'd2 : 3'(type_tab[i]);
    w = addr_tab[i][11:2];
    if (type_tab[i] == req_line) begin
      for (int k = 0; k < line_beats; k++) begin
        shadow[{w[9:2], 2'(k)}] = data_tab[i][32*k +: 32];
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (strb_tab[i][b]) shadow[w][8*b +: 8] = data_tab[i][8*b +: 8];
      end
    end
  endtask

  // runs either read port or both and checks every returned beat
  task automatic run_reads(input logic use_i, input logic use_d, input req_type_e t,
                           input logic [31:0] ia, input logic [31:0] da);
    int ic;
    int dc;
    logic i_done;
    logic d_done;
    logic i_taken;
    ic = 0;
    dc = 0;
    i_done = !use_i;
    d_done = !use_d;
    i_taken = 1'b0;
    ar_addr_exp[0] = ia;
    ar_addr_exp[1] = da;
    ar_len_exp     = 8'(beat_count(t) - 1);
    ar_size_exp    = (t == req_line) ? 3'd2 : 3'(t);
    @(posedge aclk);
    inst_rd_req  <= use_i;
    inst_rd_type <= t;
    inst_rd_addr <= ia;
    data_rd_req  <= use_d;
    data_rd_type <= t;
    data_rd_addr <= da;
    while (!(i_done && d_done)) begin
      @(posedge aclk);
      if (inst_rd_req && inst_rd_rdy) begin
        inst_rd_req <= 1'b0;
        i_taken = 1'b1;
      end
      if (data_rd_req && data_rd_rdy) data_rd_req <= 1'b0;
      if (inst_ret_valid) begin
        if (i_done) begin
          $display("*** FAILED ***");
          $fatal(1, "instruction port got a beat it did not ask for");
        end
        check_value(inst_ret_data, shadow[ia[11:2] + 10'(ic)], "inst beat");
        check_value(inst_ret_last, (ic == beat_count(t) - 1), "inst last");
        i_done = inst_ret_last;
        ic++;
      end
      if (data_ret_valid) begin
        if (d_done) begin
          $display("*** FAILED ***");
          $fatal(1, "data port got a beat it did not ask for");
        end
        check_value(data_ret_data, shadow[da[11:2] + 10'(dc)], "data beat");
        check_value(data_ret_last, (dc == beat_count(t) - 1), "data last");
        // the inst read must be taken while the data read is still open
        if (use_i && data_ret_last) begin
          check_value(i_taken, 1'b1, "inst taken during data read");
        end
        d_done = data_ret_last;
        dc++;
      end
    end
  endtask

  initial begin
    aclk = 0;
    rst_n = 0;
    cycles = 0;
    inst_rd_req = 0;
    inst_rd_type = req_word;
    inst_rd_addr = '0;
    data_rd_req = 0;
    data_rd_type = req_word;
    data_rd_addr = '0;
    data_wr_req = 0;
    data_wr_type = req_word;
    data_wr_addr = '0;
    data_wr_wstrb = '0;
    data_wr_data = '0;
    for (int i = 0; i < 1024; i++) begin
      shadow[i] = 32'(i) ^ 32'h5a5a0000;
    end
    set_row(0, 2'd0, req_line, 32'h100, '0, 4'h0);
    set_row(1, 2'd1, req_word, 32'h204, '0, 4'h0);
    set_row(2, 2'd2, req_line, 32'h300, 128'h0badf00d_cafe0003_beef0002_feed0001, 4'hf);
    set_row(3, 2'd1, req_line, 32'h300, '0, 4'h0);
    set_row(4, 2'd2, req_word, 32'h40c, 128'hdeadbeef, 4'b0101);
    set_row(5, 2'd1, req_word, 32'h40c, '0, 4'h0);
    set_row(6, 2'd3, req_line, 32'h500, '0, 4'h0);
    set_row(7, 2'd3, req_word, 32'h128, '0, 4'h0);
    set_row(8, 2'd2, req_half, 32'h208, 128'h12345678, 4'b1100);
    set_row(9, 2'd1, req_word, 32'h208, '0, 4'h0);
    repeat (16) @(posedge aclk);
    rst_n <= 1'b1;
    @(posedge aclk);
    @(posedge aclk);
    check_value({arvalid, awvalid, wvalid, inst_ret_valid, data_ret_valid}, 0, "valids");
    check_value({rready, bready, inst_rd_rdy, data_rd_rdy, data_wr_rdy}, 5'h1f, "readies");
    for (int i = 0; i < rows; i++) begin
      case (op_tab[i])
        2'd0: run_reads(1'b1, 1'b0, type_tab[i], addr_tab[i], '0);
        2'd1: run_reads(1'b0, 1'b1, type_tab[i], '0, addr_tab[i]);
        2'd2: send_write(i);
        default: run_reads(1'b1, 1'b1, type_tab[i], addr_tab[i], addr_tab[i] + 32'h100);
      endcase
    end
    while (!data_wr_rdy) @(posedge aclk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

//--- dv/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic [3:0]        arid,
  input  logic [addr_w-1:0] araddr,
  input  logic [7:0]        arlen,
  input  logic              arvalid,
  output logic              arready,
  output logic [3:0]        rid,
  output logic [word_w-1:0] rdata,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  input  logic [3:0]        awid,
  input  logic [addr_w-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [word_w-1:0] wdata,
  input  logic [3:0]        wstrb,
  input  logic              wlast,
  input  logic              wvalid,
  output logic              wready,
  output logic [3:0]        bid,
  output logic              bvalid,
  input  logic              bready
);

  logic [31:0] mem [0:1023];
  logic [31:0] lfsr;
  logic [31:0] q_addr [$];
  logic [7:0]  q_len [$];
  logic [3:0]  q_id [$];
  logic [1:0]  ar_wait;
  logic [1:0]  r_wait;
  logic [1:0]  aw_wait;
  logic [1:0]  w_wait;
  logic [9:0]  r_beat;
  logic [9:0]  w_beat;
  logic        aw_got;
  logic [31:0] aw_addr_q;
  logic [3:0]  aw_id_q;

  // galois lfsr stepped once per bit taken
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return b;
  endfunction

  function automatic logic [1:0] next_delay();
    logic [1:0] d;
    d[0] = lfsr_bit();
    d[1] = lfsr_bit();
    return d;
  endfunction

  always @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i] = 32'(i) ^ 32'h5a5a0000;
      end
      lfsr = 32'h78903b68;
      q_addr.delete();
      q_len.delete();
      q_id.delete();
      ar_wait = 0;
      r_wait  = 0;
      aw_wait = 0;
      w_wait  = 0;
      r_beat  = 0;
      w_beat  = 0;
      aw_got  = 0;
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      rid     <= '0;
      rdata   <= '0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bid     <= '0;
    end else begin
      // read addresses queue up so two reads can be open
      if (arvalid && arready) begin
        q_addr.push_back(araddr);
        q_len.push_back(arlen);
        q_id.push_back(arid);
        arready <= 1'b0;
        ar_wait = next_delay();
      end else if (!arready) begin
        if (ar_wait == 0) arready <= 1'b1;
        else ar_wait--;
      end
      // read data goes out in order of arrival
      if (rvalid && rready) begin
        if (rlast) begin
          void'(q_addr.pop_front());
          void'(q_len.pop_front());
          void'(q_id.pop_front());
          rvalid <= 1'b0;
          rlast  <= 1'b0;
          r_beat = 0;
          r_wait = next_delay();
        end else begin
          r_beat++;
          rdata <= mem[q_addr[0][11:2] + r_beat];
          rlast <= (r_beat == 10'(q_len[0]));
        end
      end else if (!rvalid && q_addr.size() > 0) begin
        if (r_wait == 0) begin
          rvalid <= 1'b1;
          rid    <= q_id[0];
          rdata  <= mem[q_addr[0][11:2]];
          rlast  <= (q_len[0] == 0);
        end else begin
          r_wait--;
        end
      end
      // write response
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got = 0;
      end
      // write address
      if (awvalid && awready) begin
        aw_got    = 1;
        aw_addr_q = awaddr;
        aw_id_q   = awid;
        w_beat    = 0;
        awready <= 1'b0;
        aw_wait = next_delay();
      end else if (!awready && !aw_got) begin
        if (aw_wait == 0) awready <= 1'b1;
        else aw_wait--;
      end
      // write data only once the address is known
      if (wvalid && wready) begin
        for (int b = 0; b < 4; b++) begin
          if (wstrb[b]) mem[aw_addr_q[11:2] + w_beat][8*b +: 8] = wdata[8*b +: 8];
        end
        w_beat++;
        wready <= 1'b0;
        w_wait = next_delay();
        if (wlast) begin
          bvalid <= 1'b1;
          bid    <= aw_id_q;
        end
      end else if (!wready && aw_got && !bvalid) begin
        if (w_wait == 0) wready <= 1'b1;
        else w_wait--;
      end
    end
  end

endmodule

//--- design/axi_bridge_top.sv
`timescale 1ns/100ps

module axi_bridge_top import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              rst_n,
  // instruction read port
  input  logic              inst_rd_req,
  input  req_type_e         inst_rd_type,
  input  logic [addr_w-1:0] inst_rd_addr,
  output logic              inst_rd_rdy,
  output logic              inst_ret_valid,
  output logic              inst_ret_last,
  output logic [word_w-1:0] inst_ret_data,
  // data read port
  input  logic              data_rd_req,
  input  req_type_e         data_rd_type,
  input  logic [addr_w-1:0] data_rd_addr,
  output logic              data_rd_rdy,
  output logic              data_ret_valid,
  output logic              data_ret_last,
  output logic [word_w-1:0] data_ret_data,
  // data write port
  input  logic              data_wr_req,
  input  req_type_e         data_wr_type,
  input  logic [addr_w-1:0] data_wr_addr,
  input  logic [3:0]        data_wr_wstrb,
  input  logic [line_w-1:0] data_wr_data,
  output logic              data_wr_rdy,
  // axi read address
  output logic [3:0]        arid,
  output logic [addr_w-1:0] araddr,
  output logic [7:0]        arlen,
  output logic [2:0]        arsize,
  output logic [1:0]        arburst,
  output logic              arvalid,
  input  logic              arready,
  // axi read data
  input  logic [3:0]        rid,
  input  logic [word_w-1:0] rdata,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready,
  // axi write address
  output logic [3:0]        awid,
  output logic [addr_w-1:0] awaddr,
  output logic [7:0]        awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic              awvalid,
  input  logic              awready,
  // axi write data
  output logic [word_w-1:0] wdata,
  output logic [3:0]        wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  // axi write response
  input  logic [3:0]        bid,
  input  logic              bvalid,
  output logic              bready
);

  logic              issue_inst;
  logic              issue_data;
  logic              inst_busy;
  logic              data_busy;
  logic              wr_busy;
  logic [addr_w-1:0] wr_line_addr;

  req_arbiter u_req_arbiter (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .inst_rd_req  (inst_rd_req),
    .inst_rd_type (inst_rd_type),
    .inst_rd_addr (inst_rd_addr),
    .data_rd_req  (data_rd_req),
    .data_rd_type (data_rd_type),
    .data_rd_addr (data_rd_addr),
    .inst_busy    (inst_busy),
    .data_busy    (data_busy),
    .wr_busy      (wr_busy),
    .wr_line_addr (wr_line_addr),
    .arready      (arready),
    .inst_rd_rdy  (inst_rd_rdy),
    .data_rd_rdy  (data_rd_rdy),
    .issue_inst   (issue_inst),
    .issue_data   (issue_data),
    .arid         (arid),
    .araddr       (araddr),
    .arlen        (arlen),
    .arsize       (arsize),
    .arburst      (arburst),
    .arvalid      (arvalid)
  );

  write_burst u_write_burst (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .data_wr_req   (data_wr_req),
    .data_wr_type  (data_wr_type),
    .data_wr_addr  (data_wr_addr),
    .data_wr_wstrb (data_wr_wstrb),
    .data_wr_data  (data_wr_data),
    .awready       (awready),
    .wready        (wready),
    .bvalid        (bvalid),
    .bid           (bid),
    .data_wr_rdy   (data_wr_rdy),
    .wr_busy       (wr_busy),
    .wr_line_addr  (wr_line_addr),
    .awid          (awid),
    .awaddr        (awaddr),
    .awlen         (awlen),
    .awsize        (awsize),
    .awburst       (awburst),
    .awvalid       (awvalid),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wlast         (wlast),
    .wvalid        (wvalid),
    .bready        (bready)
  );

  read_return u_read_return (
    .aclk           (aclk),
    .rst_n          (rst_n),
    .issue_inst     (issue_inst),
    .issue_data     (issue_data),
    .rid            (rid),
    .rdata          (rdata),
    .rlast          (rlast),
    .rvalid         (rvalid),
    .rready         (rready),
    .inst_busy      (inst_busy),
    .data_busy      (data_busy),
    .inst_ret_valid (inst_ret_valid),
    .inst_ret_last  (inst_ret_last),
    .inst_ret_data  (inst_ret_data),
    .data_ret_valid (data_ret_valid),
    .data_ret_last  (data_ret_last),
    .data_ret_data  (data_ret_data)
  );

endmodule

//--- design/read_return.sv
`timescale 1ns/100ps

module read_return import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              issue_inst,
  input  logic              issue_data,
  input  logic [3:0]        rid,
  input  logic [word_w-1:0] rdata,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready,
  output logic              inst_busy,
  output logic              data_busy,
  output logic              inst_ret_valid,
  output logic              inst_ret_last,
  output logic [word_w-1:0] inst_ret_data,
  output logic              data_ret_valid,
  output logic              data_ret_last,
  output logic [word_w-1:0] data_ret_data
);

  logic inst_hit;
  logic data_hit;

  // caches take every beat
  assign rready = 1'b1;

  assign inst_hit = rvalid && (rid == axi_id_inst);
  assign data_hit = rvalid && (rid == axi_id_data);

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      inst_busy <= 1'b0;
      data_busy <= 1'b0;
    end else begin
      if (issue_inst) begin
        inst_busy <= 1'b1;
      end else if (inst_hit && rlast) begin
        inst_busy <= 1'b0;
      end
      if (issue_data) begin
        data_busy <= 1'b1;
      end else if (data_hit && rlast) begin
        data_busy <= 1'b0;
      end
    end
  end

  // demux by id
  assign inst_ret_valid = inst_hit;
  assign inst_ret_last  = inst_hit && rlast;
  assign inst_ret_data  = rdata;

  assign data_ret_valid = data_hit;
  assign data_ret_last  = data_hit && rlast;
  assign data_ret_data  = rdata;

endmodule

//--- design/write_burst.sv
`timescale 1ns/100ps

module write_burst import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              data_wr_req,
  input  req_type_e         data_wr_type,
  input  logic [addr_w-1:0] data_wr_addr,
  input  logic [3:0]        data_wr_wstrb,
  input  logic [line_w-1:0] data_wr_data,
  input  logic              awready,
  input  logic              wready,
  input  logic              bvalid,
  input  logic [3:0]        bid,
  output logic              data_wr_rdy,
  output logic              wr_busy,
  output logic [addr_w-1:0] wr_line_addr,
  output logic [3:0]        awid,
  output logic [addr_w-1:0] awaddr,
  output logic [7:0]        awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic              awvalid,
  output logic [word_w-1:0] wdata,
  output logic [3:0]        wstrb,
  output logic              wlast,
  output logic              wvalid,
  output logic              bready
);

  wr_state_e state;
  logic      wr_take;
  logic      aw_hs;
  logic      w_hs;
  logic      w_last_hs;
  logic      is_line;

  logic [addr_w-1:0] addr_q;
  logic [line_w-1:0] line_q;
  logic [3:0]        strb_q;
  req_type_e         type_q;

  logic [$clog2(line_beats)-1:0] beat_cnt;
  logic [$clog2(line_beats)-1:0] last_beat;

  assign data_wr_rdy = (state == wr_idle);
  assign wr_take     = data_wr_req && data_wr_rdy;

  // busy already in the accepting cycle so a same-line read is held
  assign wr_busy      = wr_take || (state != wr_idle);
  assign wr_line_addr = (state == wr_idle) ? data_wr_addr : addr_q;

  assign is_line   = (type_q == req_line);
  assign last_beat = is_line ? ($clog2(line_beats))'(line_beats - 1) : '0;

  assign aw_hs     = awvalid && awready;
  assign w_hs      = wvalid && wready;
  assign w_last_hs = w_hs && wlast;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= wr_idle;
      awvalid  <= 1'b0;
      wvalid   <= 1'b0;
      beat_cnt <= '0;
    end else begin
      case (state)
        wr_idle: begin
          if (wr_take) begin
            state    <= wr_burst;
            awvalid  <= 1'b1;
            wvalid   <= 1'b1;
            beat_cnt <= '0;
          end
        end
        wr_burst: begin
          if (aw_hs) begin
            awvalid <= 1'b0;
          end
          if (w_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (w_last_hs) begin
            wvalid <= 1'b0;
          end
          // aw and w finish in either order
          if ((!awvalid || aw_hs) && (!wvalid || w_last_hs)) begin
            state <= wr_resp;
          end
        end
        wr_resp: begin
          if (bvalid && bid == axi_id_data) begin
            state <= wr_idle;
          end
        end
        default: state <= wr_idle;
      endcase
    end
  end

  // line shifts down one word per accepted beat so the low word goes first
  always_ff @(posedge aclk) begin
    if (wr_take) begin
      addr_q <= data_wr_addr;
      line_q <= data_wr_data;
      strb_q <= data_wr_wstrb;
      type_q <= data_wr_type;
    end else if (w_hs) begin
      line_q <= line_q >> word_w;
    end
  end

  assign awid    = axi_id_data;
  assign awaddr  = addr_q;
  assign awlen   = is_line ? 8'(line_beats - 1) : 8'd0;
  assign awsize  = is_line ? 3'd2 : type_q;
  assign awburst = burst_incr;

  assign wdata = line_q[word_w-1:0];
  assign wstrb = is_line ? 4'hf : strb_q;
  assign wlast = (beat_cnt == last_beat);

  assign bready = (state != wr_burst);

endmodule

//--- design/req_arbiter.sv
`timescale 1ns/100ps

module req_arbiter import bridge_pkg::*; (
  input  logic              aclk,
  input  logic              rst_n,
  input  logic              inst_rd_req,
  input  req_type_e         inst_rd_type,
  input  logic [addr_w-1:0] inst_rd_addr,
  input  logic              data_rd_req,
  input  req_type_e         data_rd_type,
  input  logic [addr_w-1:0] data_rd_addr,
  input  logic              inst_busy,
  input  logic              data_busy,
  input  logic              wr_busy,
  input  logic [addr_w-1:0] wr_line_addr,
  input  logic              arready,
  output logic              inst_rd_rdy,
  output logic              data_rd_rdy,
  output logic              issue_inst,
  output logic              issue_data,
  output logic [3:0]        arid,
  output logic [addr_w-1:0] araddr,
  output logic [7:0]        arlen,
  output logic [2:0]        arsize,
  output logic [1:0]        arburst,
  output logic              arvalid
);

  ar_state_e         state;
  logic              ar_free;
  logic              raw_hit;
  logic              take_any;
  req_type_e         take_type;
  logic [addr_w-1:0] take_addr;

  assign ar_free = (state == ar_idle);

  // data read to a line whose write is still waiting for its response
  assign raw_hit = wr_busy &&
                   (data_rd_addr[addr_w-1:line_off_w] == wr_line_addr[addr_w-1:line_off_w]);

  assign data_rd_rdy = ar_free && !data_busy && !raw_hit;

  // data goes first when both ask in the same cycle
  assign inst_rd_rdy = ar_free && !inst_busy && !(data_rd_req && data_rd_rdy);

  assign issue_data = data_rd_req && data_rd_rdy;
  assign issue_inst = inst_rd_req && inst_rd_rdy;
  assign take_any   = issue_data || issue_inst;

  assign take_type = issue_data ? data_rd_type : inst_rd_type;
  assign take_addr = issue_data ? data_rd_addr : inst_rd_addr;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ar_idle;
    end else begin
      case (state)
        ar_idle: begin
          if (take_any) begin
            state <= ar_send;
          end
        end
        ar_send: begin
          if (arready) begin
            state <= ar_idle;
          end
        end
        default: state <= ar_idle;
      endcase
    end
  end

  // address payload held while arvalid waits for arready
  always_ff @(posedge aclk) begin
    if (take_any) begin
      arid   <= issue_data ? axi_id_data : axi_id_inst;
      araddr <= take_addr;
      if (take_type == req_line) begin
        arlen  <= 8'(line_beats - 1);
        arsize <= 3'd2;
      end else begin
        arlen  <= 8'd0;
        arsize <= take_type;
      end
    end
  end

  assign arburst = burst_incr;
  assign arvalid = (state == ar_send);

endmodule

//--- design/bridge_pkg.sv
package bridge_pkg;

  // bus widths
  localparam int addr_w     = 32;
  localparam int word_w     = 32;
  localparam int line_w     = 128;
  localparam int line_beats = line_w / word_w;
  localparam int line_off_w = 4;

  // one axi id per read source
  localparam logic [3:0] axi_id_inst = 4'd0;
  localparam logic [3:0] axi_id_data = 4'd1;

  localparam logic [1:0] burst_incr = 2'b01;

  // request size as the caches encode it
  typedef enum logic [2:0] {
    req_byte = 3'b000,
    req_half = 3'b001,
    req_word = 3'b010,
    req_line = 3'b100
  } req_type_e;

  typedef enum logic [1:0] {
    ar_idle = 2'b00,
    ar_send = 2'b01
  } ar_state_e;

  typedef enum logic [1:0] {
    wr_idle  = 2'b00,
    wr_burst = 2'b01,
    wr_resp  = 2'b10
  } wr_state_e;

endpackage
